// ==== ooo_core.f ====
+incdir+source
source/ooo_core_pkg.sv
source/issue_buffer.sv
source/alu_lane.sv
source/reorder_buffer.sv
source/ooo_core.sv
verif/ooo_core_properties.sv
verif/ooo_core_tb.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := ooo_core_tb
FILELIST   := ooo_core.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_FLAGS  := +verilator+error+limit+1000
PASS_TEXT  := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/ooo_core_tb.sv ====
// testbench for the core slice, written for WAYS of 2
// ops come from an xorshift generator, expected results from the opcode rules
// inputs change 1 ns after the rising edge, commit is sampled on the falling edge
// bound properties add their violation count to the totals

`timescale 1ns/1ps

`include "ooo_core_config.svh"

module ooo_core_tb import ooo_core_pkg::*; ();

	localparam int STALL_LIMIT = 200;
	localparam int DRAIN_LIMIT = 600;
	localparam int ERROR_LIMIT = 100;
	localparam int HALT_CYCLES = 30;

	logic                  clock;
	logic                  rst_n;
	dispatch_t [`WAYS-1:0] dispatch;
	logic                  stall;
	commit_t [`WAYS-1:0]   commit;
	error_t                error_status;

	// reference model, oldest expected commit at the front
	commit_t exp_q [$];

	logic [31:0] rng_state = 32'd35428;
	int          errors = 0;
	int          checks = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          test_start_errors = 0;
	bit          saw_stall = 1'b0;
	bit          timed_out = 1'b0;

	ooo_core ooo_core_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.dispatch     (dispatch),
		.stall        (stall),
		.commit       (commit),
		.error_status (error_status)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus and model helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic dispatch_t make_op(input op_t op, input logic [`XLEN-1:0] a,
		input logic [`XLEN-1:0] b, input logic [`REG_BITS-1:0] dest);
		dispatch_t d;
		d.valid = 1'b1;
		d.op    = op;
		d.src_a = a;
		d.src_b = b;
		d.dest  = dest;
		return d;
	endfunction

	// shifts only when asked, amount is whatever lands in src_b
	function automatic dispatch_t random_op(input bit with_shift);
		logic [31:0] r;
		op_t         op;
		r = xorshift32();
		if (with_shift) begin
			op = op_t'(3'(r % 7));
		end else begin
			op = op_t'(3'(r % 5));
		end
		return make_op(op, xorshift32(), xorshift32(), r[12:8]);
	endfunction

	// architectural result of one op
	function automatic commit_t expected_commit(input dispatch_t d);
		commit_t c;
		c.valid = 1'b1;
		c.dest  = d.dest;
		case (d.op)
			OP_ADD:  c.data = d.src_a + d.src_b;
			OP_SUB:  c.data = d.src_a - d.src_b;
			OP_AND:  c.data = d.src_a & d.src_b;
			OP_OR:   c.data = d.src_a | d.src_b;
			OP_XOR:  c.data = d.src_a ^ d.src_b;
			OP_SLL:  c.data = d.src_a << d.src_b[4:0];
			OP_SRL:  c.data = d.src_a >> d.src_b[4:0];
			default: c.data = '0;
		endcase
		return c;
	endfunction

	function automatic int total_errors();
		return errors + int'(ooo_core_inst.ooo_core_properties_inst.violations);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// sequencing tasks, all entered and left 1 ns after a rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string what);
		timed_out = 1'b1;
		$display("timeout at %0t: %s", $time, what);
		$display("Done: errors found");
		$finish;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (16) @(posedge clock);
		#1;
		rst_n = 1'b1;
	endtask

	// hold the pair until stall drops, n_expect ways go into the model
	task automatic send_ops(input dispatch_t op0, input dispatch_t op1, input int n_expect);
		int waited;
		waited      = 0;
		dispatch[0] = op0;
		dispatch[1] = op1;
		while (stall && (waited < STALL_LIMIT)) begin
			saw_stall = 1'b1;
			@(posedge clock);
			#1;
			waited++;
		end
		if (stall) begin
			abort_run("dispatch held off by stall for too long");
		end else begin
			if ((n_expect > 0) && op0.valid) begin
				exp_q.push_back(expected_commit(op0));
			end
			if ((n_expect > 1) && op1.valid) begin
				exp_q.push_back(expected_commit(op1));
			end
			@(posedge clock);
			#1;
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0) && (waited < DRAIN_LIMIT)) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (exp_q.size() != 0) begin
			abort_run("expected commits still outstanding");
		end
	endtask

	task automatic wait_error();
		int waited;
		waited = 0;
		while ((error_status != ILLEGAL_INST) && (waited < ERROR_LIMIT)) begin
			@(posedge clock);
			#1;
			waited++;
		end
		if (error_status != ILLEGAL_INST) begin
			abort_run("error status never reported the illegal op");
		end
	endtask

	task automatic finish_test(input string name);
		if (total_errors() == test_start_errors) begin
			tests_passed++;
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, total_errors() - test_start_errors);
		end
		test_start_errors = total_errors();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// commit checker
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		commit_t want;
		if (rst_n) begin
			for (int k = 0; k < `WAYS; k++) begin
				if (commit[k].valid) begin
					assert (exp_q.size() != 0) else begin
						errors++;
						$display("commit on way %0d at %0t with no op outstanding", k, $time);
					end
					if (exp_q.size() != 0) begin
						want = exp_q.pop_front();
						checks++;
						assert ((commit[k].dest == want.dest) && (commit[k].data == want.data))
						else begin
							errors++;
							$display("mismatch at %0t: way %0d dest %0d data %h, want %0d %h",
								$time, k, commit[k].dest, commit[k].data, want.dest, want.data);
						end
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int          k;
		logic [31:0] r;
		dispatch_t   op1;
		rst_n    = 1'b0;
		dispatch = '0;
		apply_reset();
		// idle state after reset is checked by the bound properties
		repeat (4) @(posedge clock);
		#1;
		finish_test("reset_idle");

		// single-cycle ops, way 1 sometimes empty
		for (k = 0; k < 24; k++) begin
			r   = xorshift32();
			op1 = '0;
			if (r[0]) begin
				op1 = random_op(1'b0);
			end
			send_ops(random_op(1'b0), op1, 2);
		end
		dispatch = '0;
		wait_drain();
		finish_test("random_alu");

		// long shifts in front, short ops finish first
		send_ops(make_op(OP_SLL, xorshift32(), 32'd31, 5'd1), random_op(1'b0), 2);
		send_ops(make_op(OP_SRL, xorshift32(), 32'd20, 5'd3), random_op(1'b0), 2);
		for (k = 0; k < 3; k++) begin
			send_ops(random_op(1'b0), random_op(1'b0), 2);
		end
		dispatch = '0;
		wait_drain();
		finish_test("shift_order");

		// back-to-back pairs with shifts until the rob fills
		saw_stall = 1'b0;
		for (k = 0; k < 40; k++) begin
			send_ops(random_op(1'b1), random_op(1'b1), 2);
		end
		dispatch = '0;
		wait_drain();
		assert (saw_stall) else begin
			errors++;
			$display("stall never rose during the back-to-back burst at %0t", $time);
		end
		finish_test("full_burst");

		// older ops retire, the illegal op and all younger ones never do
		for (k = 0; k < 3; k++) begin
			send_ops(random_op(1'b0), random_op(1'b0), 2);
		end
		send_ops(make_op(OP_ILLEGAL, xorshift32(), xorshift32(), 5'd7), random_op(1'b0), 0);
		dispatch[0] = random_op(1'b0);
		dispatch[1] = random_op(1'b0);
		wait_drain();
		wait_error();
		for (k = 0; k < HALT_CYCLES; k++) begin
			assert (stall && (error_status == ILLEGAL_INST)) else begin
				errors++;
				$display("mismatch at %0t: stall %b error_status %0d in halted core",
					$time, stall, error_status);
			end
			@(posedge clock);
			#1;
		end
		finish_test("illegal_halt");

		// reset clears the halt
		dispatch = '0;
		apply_reset();
		repeat (4) @(posedge clock);
		#1;

		if (!timed_out) begin
			$display("summary: %0d tests passed, %0d failed, %0d commits checked, %0d errors",
				tests_passed, tests_failed, checks, total_errors());
			if (total_errors() == 0) begin
				$display("Done: no errors");
			end else begin
				$display("Done: errors found");
			end
			$finish;
		end
	end

endmodule

// ==== verif/ooo_core_properties.sv ====
// protocol checks for the core slice bound to the top level
// written for WAYS of 2 as set in the config header
// each failure also bumps violations for the testbench totals

`timescale 1ns/1ps

`include "ooo_core_config.svh"

module ooo_core_properties import ooo_core_pkg::*; (
	input logic                  clock,
	input logic                  rst_n,
	input dispatch_t [`WAYS-1:0] dispatch,
	input logic                  stall,
	input commit_t [`WAYS-1:0]   commit,
	input error_t                error_status,
	input logic [`WAYS-1:0]      issue_valid,
	input logic [`WAYS-1:0]      busy,
	input cdb_t [`WAYS-1:0]      cdb
);

	int unsigned violations = 0;

	// valid bits pulled out of the structs
	logic [`WAYS-1:0] commit_valid;
	logic [`WAYS-1:0] cdb_valid;

	for (genvar g = 0; g < `WAYS; g++) begin : g_bits
		assign commit_valid[g] = commit[g].valid;
		assign cdb_valid[g]    = cdb[g].valid;
	end

	////////////////////////////////////////////////////////////////////////////
	// core level
	////////////////////////////////////////////////////////////////////////////

	// first sampled edge out of reset sees an idle core
	reset_idle: assert property (@(posedge clock) $rose(rst_n) |->
		(commit_valid == '0) && !stall && (error_status == NO_ERROR) &&
		(issue_valid == '0) && (cdb_valid == '0) && (busy == '0))
		else begin violations++; $error("core not idle after reset release"); end

	// commit is a prefix from way 0
	commit_prefix: assert property (@(posedge clock) disable iff (!rst_n)
		commit_valid[1] |-> commit_valid[0])
		else begin violations++; $error("commit way 1 valid without way 0"); end

	// way 1 only together with way 0 on dispatch
	dispatch_prefix: assert property (@(posedge clock) disable iff (!rst_n)
		dispatch[1].valid |-> dispatch[0].valid)
		else begin violations++; $error("dispatch way 1 valid without way 0"); end

	// sticky until reset
	error_sticky: assert property (@(posedge clock) disable iff (!rst_n)
		(error_status == ILLEGAL_INST) |=> (error_status == ILLEGAL_INST))
		else begin violations++; $error("error status cleared without reset"); end

	// halted core neither accepts nor retires
	error_halts: assert property (@(posedge clock) disable iff (!rst_n)
		(error_status != NO_ERROR) |-> (stall && (commit_valid == '0)))
		else begin violations++; $error("core still active after an error"); end

	////////////////////////////////////////////////////////////////////////////
	// per lane
	////////////////////////////////////////////////////////////////////////////

	for (genvar g = 0; g < `WAYS; g++) begin : g_lane_checks
		// single-cycle completion pulse
		cdb_pulse: assert property (@(posedge clock) disable iff (!rst_n)
			cdb_valid[g] |=> !cdb_valid[g])
			else begin violations++; $error("cdb valid held for two cycles"); end

		// an issued lane is busy on the next edge
		issue_busy: assert property (@(posedge clock) disable iff (!rst_n)
			issue_valid[g] |=> busy[g])
			else begin violations++; $error("lane not busy after taking an issue"); end
	end

endmodule

bind ooo_core ooo_core_properties ooo_core_properties_inst (
	.clock        (clock),
	.rst_n        (rst_n),
	.dispatch     (dispatch),
	.stall        (stall),
	.commit       (commit),
	.error_status (error_status),
	.issue_valid  (issue_valid),
	.busy         (busy),
	.cdb          (cdb)
);

// ==== source/ooo_core.sv ====
// top of the core slice, structural only
// dispatch is a per-way valid strobe, honoured only while stall is low
// way 1 may be valid only together with way 0, way 0 is older
// commit is in program order, error_status is sticky until reset

`timescale 1ns/1ps

`include "ooo_core_config.svh"

module ooo_core import ooo_core_pkg::*; (
	input  logic                  clock,
	input  logic                  rst_n,
	input  dispatch_t [`WAYS-1:0] dispatch,
	output logic                  stall,
	output commit_t [`WAYS-1:0]   commit,
	output error_t                error_status
);

	// rob to issue buffer
	logic                 accept;
	rob_idx_t [`WAYS-1:0] alloc_idx;

	// issue buffer to lanes
	issue_t [`WAYS-1:0] issue;
	logic [`WAYS-1:0]   issue_valid;
	logic [`WAYS-1:0]   busy;

	// common data bus, one slot per lane
	cdb_t [`WAYS-1:0] cdb;

	issue_buffer issue_buffer_inst (
		.clock       (clock),
		.rst_n       (rst_n),
		.dispatch    (dispatch),
		.accept      (accept),
		.alloc_idx   (alloc_idx),
		.busy        (busy),
		.issue       (issue),
		.issue_valid (issue_valid)
	);

	// identical lanes, lane g drives bus slot g
	for (genvar g = 0; g < `WAYS; g++) begin : g_lane
		alu_lane alu_lane_inst (
			.clock       (clock),
			.rst_n       (rst_n),
			.issue       (issue[g]),
			.issue_valid (issue_valid[g]),
			.busy        (busy[g]),
			.cdb         (cdb[g])
		);
	end

	reorder_buffer reorder_buffer_inst (
		.clock        (clock),
		.rst_n        (rst_n),
		.dispatch     (dispatch),
		.cdb          (cdb),
		.alloc_idx    (alloc_idx),
		.accept       (accept),
		.stall        (stall),
		.commit       (commit),
		.error_status (error_status)
	);

endmodule

// ==== source/reorder_buffer.sv ====
// reorder buffer with in-order commit of up to WAYS entries per cycle
// commit is combinational from entry state, head moves on the next edge
// an illegal op at the head halts commit and dispatch until reset
// stall is high while fewer than WAYS entries are free

`timescale 1ns/1ps

`include "ooo_core_config.svh"

module reorder_buffer import ooo_core_pkg::*; (
	input  logic                  clock,
	input  logic                  rst_n,
	input  dispatch_t [`WAYS-1:0] dispatch,
	input  cdb_t [`WAYS-1:0]      cdb,
	output rob_idx_t [`WAYS-1:0]  alloc_idx,
	output logic                  accept,
	output logic                  stall,
	output commit_t [`WAYS-1:0]   commit,
	output error_t                error_status
);

	localparam int CNT_BITS = $clog2(`ROB_DEPTH) + 1;

	// per-entry payload
	logic [`REG_BITS-1:0] dest_q    [`ROB_DEPTH];
	logic [`XLEN-1:0]     data_q    [`ROB_DEPTH];
	logic                 illegal_q [`ROB_DEPTH];

	// per-entry control
	logic [`ROB_DEPTH-1:0] done_q;

	rob_idx_t            head_q;
	rob_idx_t            tail_q;
	logic [CNT_BITS-1:0] free_q;
	error_t              err_q;

	logic [CNT_BITS-1:0] in_use;
	logic [CNT_BITS-1:0] n_alloc;
	logic [CNT_BITS-1:0] n_retire;
	logic                hit_illegal;
	// true while every older slot in this cycle has retired
	logic                chain;
	rob_idx_t            rd_idx;

	// same rule as rob_is_full, plus the sticky halt
	assign stall        = (free_q < CNT_BITS'(`WAYS)) || (err_q != NO_ERROR);
	assign accept       = !stall;
	assign error_status = err_q;
	assign in_use       = CNT_BITS'(`ROB_DEPTH) - free_q;

	////////////////////////////////////////////////////////////////////////////
	// allocation
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		n_alloc = '0;
		for (int k = 0; k < `WAYS; k++) begin
			alloc_idx[k] = rob_idx_t'(tail_q + n_alloc);
			if (accept && dispatch[k].valid) begin
				n_alloc = n_alloc + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// retirement
	////////////////////////////////////////////////////////////////////////////

	// contiguous done prefix from head, stops at the first illegal
	always_comb begin
		n_retire    = '0;
		hit_illegal = 1'b0;
		chain       = (err_q == NO_ERROR);
		commit      = '0;
		for (int k = 0; k < `WAYS; k++) begin
			rd_idx = rob_idx_t'(head_q + k);
			if (chain && (CNT_BITS'(k) < in_use) && done_q[rd_idx]) begin
				if (illegal_q[rd_idx]) begin
					// reported through status, never as a commit
					hit_illegal = 1'b1;
					chain       = 1'b0;
				end else begin
					commit[k].valid = 1'b1;
					commit[k].dest  = dest_q[rd_idx];
					commit[k].data  = data_q[rd_idx];
					n_retire        = n_retire + 1'b1;
				end
			end else begin
				chain = 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// state update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			free_q <= CNT_BITS'(`ROB_DEPTH);
			err_q  <= NO_ERROR;
			done_q <= '0;
		end else begin
			head_q <= rob_idx_t'(head_q + n_retire);
			tail_q <= rob_idx_t'(tail_q + n_alloc);
			free_q <= free_q - n_alloc + n_retire;
			if (hit_illegal) begin
				err_q <= ILLEGAL_INST;
			end
			// new entries start pending
			for (int k = 0; k < `WAYS; k++) begin
				if (accept && dispatch[k].valid) begin
					done_q[alloc_idx[k]] <= 1'b0;
				end
			end
			// completions never hit a slot allocated this cycle
			for (int k = 0; k < `WAYS; k++) begin
				if (cdb[k].valid) begin
					done_q[cdb[k].rob_idx] <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		for (int k = 0; k < `WAYS; k++) begin
			if (accept && dispatch[k].valid) begin
				dest_q[alloc_idx[k]] <= dispatch[k].dest;
			end
		end
		for (int k = 0; k < `WAYS; k++) begin
			if (cdb[k].valid) begin
				data_q[cdb[k].rob_idx]    <= cdb[k].result;
				illegal_q[cdb[k].rob_idx] <= cdb[k].illegal;
			end
		end
	end

endmodule

// ==== source/alu_lane.sv ====
// one execution lane, one op in flight at a time
// logic and add/sub ops finish one cycle after issue
// shifts move one bit per cycle, amount is the low bits of src_b
// cdb valid is a single-cycle pulse, busy is low again in that cycle

`timescale 1ns/1ps

`include "ooo_core_config.svh"

module alu_lane import ooo_core_pkg::*; (
	input  logic   clock,
	input  logic   rst_n,
	input  issue_t issue,
	input  logic   issue_valid,
	output logic   busy,
	output cdb_t   cdb
);

	localparam int SH_BITS = $clog2(`XLEN);

	typedef enum logic {
		LANE_IDLE = 1'b0,
		LANE_EXEC = 1'b1
	} lane_state_t;

	lane_state_t state_q;

	// latched work item, acc_q doubles as the shift register
	op_t              op_q;
	logic [`XLEN-1:0] acc_q;
	logic [`XLEN-1:0] b_q;
	logic [SH_BITS-1:0] cnt_q;
	rob_idx_t         idx_q;

	logic             is_shift;
	logic             done_now;
	logic [`XLEN-1:0] result;

	// bus output registers
	logic             cdb_valid_q;
	logic [`XLEN-1:0] cdb_result_q;
	rob_idx_t         cdb_idx_q;
	logic             cdb_illegal_q;

	assign is_shift = (op_q == OP_SLL) || (op_q == OP_SRL);
	// finish unless a shift still has bits left
	assign done_now = (state_q == LANE_EXEC) && !(is_shift && (cnt_q != '0));
	assign busy     = (state_q == LANE_EXEC);

	always_comb begin
		case (op_q)
			OP_ADD:  result = acc_q + b_q;
			OP_SUB:  result = acc_q - b_q;
			OP_AND:  result = acc_q & b_q;
			OP_OR:   result = acc_q | b_q;
			OP_XOR:  result = acc_q ^ b_q;
			// shifted value already in acc, illegal just passes a
			default: result = acc_q;
		endcase
	end

	// control
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= LANE_IDLE;
			cdb_valid_q <= 1'b0;
		end else begin
			cdb_valid_q <= done_now;
			if ((state_q == LANE_IDLE) && issue_valid) begin
				state_q <= LANE_EXEC;
			end else if (done_now) begin
				state_q <= LANE_IDLE;
			end
		end
	end

	// datapath
	always_ff @(posedge clock) begin
		if (state_q == LANE_IDLE) begin
			if (issue_valid) begin
				op_q  <= issue.op;
				acc_q <= issue.src_a;
				b_q   <= issue.src_b;
				cnt_q <= issue.src_b[SH_BITS-1:0];
				idx_q <= issue.rob_idx;
			end
		end else if (is_shift && (cnt_q != '0)) begin
			// one bit per cycle
			acc_q <= (op_q == OP_SLL) ? (acc_q << 1) : (acc_q >> 1);
			cnt_q <= cnt_q - 1'b1;
		end
		if (done_now) begin
			cdb_result_q  <= result;
			cdb_idx_q     <= idx_q;
			cdb_illegal_q <= (op_q == OP_ILLEGAL);
		end
	end

	assign cdb = '{
		valid:   cdb_valid_q,
		rob_idx: cdb_idx_q,
		result:  cdb_result_q,
		illegal: cdb_illegal_q
	};

endmodule

// ==== source/issue_buffer.sv ====
// in-order holding queue between dispatch and the alu lanes
// depth equals the reorder buffer, so dispatch stall keeps it from overflow
// valid ways must be contiguous from way 0
// issue outputs are combinational from buffer state and lane busy

`timescale 1ns/1ps

`include "ooo_core_config.svh"

module issue_buffer import ooo_core_pkg::*; (
	input  logic                  clock,
	input  logic                  rst_n,
	input  dispatch_t [`WAYS-1:0] dispatch,
	input  logic                  accept,
	input  rob_idx_t [`WAYS-1:0]  alloc_idx,
	input  logic [`WAYS-1:0]      busy,
	output issue_t [`WAYS-1:0]    issue,
	output logic [`WAYS-1:0]      issue_valid
);

	localparam int CNT_BITS = $clog2(`ROB_DEPTH) + 1;

	// entry storage
	issue_t entry_q [`ROB_DEPTH];

	rob_idx_t            head_q;
	rob_idx_t            tail_q;
	logic [CNT_BITS-1:0] count_q;

	// per-cycle bookkeeping
	logic [CNT_BITS-1:0]  n_acc;
	logic [CNT_BITS-1:0]  n_issue;
	rob_idx_t [`WAYS-1:0] wr_slot;
	logic [`WAYS-1:0]     wr_en;

	////////////////////////////////////////////////////////////////////////////
	// write side
	////////////////////////////////////////////////////////////////////////////

	// accepted ways land at tail in program order
	always_comb begin
		n_acc = '0;
		for (int k = 0; k < `WAYS; k++) begin
			wr_slot[k] = rob_idx_t'(tail_q + n_acc);
			wr_en[k]   = accept && dispatch[k].valid;
			if (wr_en[k]) begin
				n_acc = n_acc + 1'b1;
			end
		end
	end

	// payload only, rob index comes straight from the rob tail
	always_ff @(posedge clock) begin
		for (int k = 0; k < `WAYS; k++) begin
			if (wr_en[k]) begin
				entry_q[wr_slot[k]] <= '{
					op:      dispatch[k].op,
					src_a:   dispatch[k].src_a,
					src_b:   dispatch[k].src_b,
					dest:    dispatch[k].dest,
					rob_idx: alloc_idx[k]
				};
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// issue side
	////////////////////////////////////////////////////////////////////////////

	// oldest waiting entries go to idle lanes, lane 0 first
	always_comb begin
		n_issue     = '0;
		issue_valid = '0;
		for (int l = 0; l < `WAYS; l++) begin
			issue[l] = entry_q[rob_idx_t'(head_q + n_issue)];
			if (!busy[l] && (n_issue < count_q)) begin
				issue_valid[l] = 1'b1;
				n_issue        = n_issue + 1'b1;
			end
		end
	end

	// pointers and occupancy
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			head_q  <= rob_idx_t'(head_q + n_issue);
			tail_q  <= rob_idx_t'(tail_q + n_acc);
			count_q <= count_q + n_acc - n_issue;
		end
	end

endmodule

// ==== source/ooo_core_pkg.sv ====
// types for the out-of-order core slice
// operands arrive as values, there is no renaming
// sizes come from the config header

`include "ooo_core_config.svh"

package ooo_core_pkg;

	// opcodes, shifts are the only multi-cycle ops
	typedef enum logic [2:0] {
		OP_ADD     = 3'd0,
		OP_SUB     = 3'd1,
		OP_AND     = 3'd2,
		OP_OR      = 3'd3,
		OP_XOR     = 3'd4,
		OP_SLL     = 3'd5,
		OP_SRL     = 3'd6,
		OP_ILLEGAL = 3'd7
	} op_t;

	// sticky core status
	typedef enum logic [1:0] {
		NO_ERROR     = 2'd0,
		ILLEGAL_INST = 2'd1
	} error_t;

	typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

	// one decoded op from outside
	typedef struct packed {
		logic                 valid;
		op_t                  op;
		logic [`XLEN-1:0]     src_a;
		logic [`XLEN-1:0]     src_b;
		logic [`REG_BITS-1:0] dest;
	} dispatch_t;

	// work item handed to a lane
	typedef struct packed {
		op_t                  op;
		logic [`XLEN-1:0]     src_a;
		logic [`XLEN-1:0]     src_b;
		logic [`REG_BITS-1:0] dest;
		rob_idx_t             rob_idx;
	} issue_t;

	// completion on the common data bus
	typedef struct packed {
		logic             valid;
		rob_idx_t         rob_idx;
		logic [`XLEN-1:0] result;
		logic             illegal;
	} cdb_t;

	// retired result, in program order
	typedef struct packed {
		logic                 valid;
		logic [`REG_BITS-1:0] dest;
		logic [`XLEN-1:0]     data;
	} commit_t;

endpackage

// ==== source/ooo_core_config.svh ====
// size constants shared by the core and its testbench
// ROB_DEPTH must be a power of two so that pointers wrap by themselves
// WAYS sets dispatch width, commit width and lane count together
// WAYS must not exceed ROB_DEPTH

`ifndef OOO_CORE_CONFIG_SVH
`define OOO_CORE_CONFIG_SVH

// ops per cycle in and out, also number of alu lanes
`define WAYS 2

// reorder buffer entries, issue buffer uses the same depth
`define ROB_DEPTH 8

// datapath width
`define XLEN 32

// architectural destination register number
`define REG_BITS 5

`endif
